/* dv/arya_programs.svh */
`ifndef ARYA_PROGRAMS_SVH
`define ARYA_PROGRAMS_SVH

//////////////////////////////////////////////////////////////////////
// test program table
//////////////////////////////////////////////////////////////////////

localparam int NUM_ROWS   = 4;
localparam int PROG_LEN   = 40;
localparam int MAX_PRESET = 4;
localparam int MAX_EXPECT = 10;
// data words cleared to the fill pattern before every row
localparam int FILL_WORDS = 80;
localparam arya_isa_pkg::mem_addr_t DATA_BASE = 10'h200;

// one memory word with its address
typedef struct packed {
    arya_isa_pkg::mem_addr_t addr;
    arya_isa_pkg::word_t     data;
} data_entry_t;

arya_isa_pkg::inst_t programs [NUM_ROWS][PROG_LEN];
data_entry_t         presets [NUM_ROWS][MAX_PRESET];
data_entry_t         expects [NUM_ROWS][MAX_EXPECT];
int                  preset_count [NUM_ROWS];
int                  expect_count [NUM_ROWS];

// register-register format
function automatic arya_isa_pkg::inst_t rtype(arya_isa_pkg::opcode_e op,
        arya_isa_pkg::reg_addr_t rd, arya_isa_pkg::reg_addr_t rs1,
        arya_isa_pkg::reg_addr_t rs2);
    return {op, rd, rs1, rs2, 13'b0};
endfunction

// immediate format, imm in [15:0]
function automatic arya_isa_pkg::inst_t itype(arya_isa_pkg::opcode_e op,
        arya_isa_pkg::reg_addr_t rd, arya_isa_pkg::reg_addr_t rs1,
        arya_isa_pkg::imm_t imm);
    return {op, rd, rs1, 2'b00, imm};
endfunction

// compare rs1 with rs2, offset in [8:0]
function automatic arya_isa_pkg::inst_t branch_inst(arya_isa_pkg::opcode_e op,
        arya_isa_pkg::reg_addr_t rs1, arya_isa_pkg::reg_addr_t rs2,
        arya_isa_pkg::pc_t offset);
    return {op, 5'd0, rs1, rs2, 4'd0, offset};
endfunction

// every address bit shows up twice in the word
function automatic arya_isa_pkg::word_t fill_word(arya_isa_pkg::mem_addr_t addr);
    return {22'h3c0f0f, addr, 22'h15a5a5, addr};
endfunction

task automatic preset_word(int row, arya_isa_pkg::mem_addr_t addr,
        arya_isa_pkg::word_t data);
    presets[row][preset_count[row]] = '{addr, data};
    preset_count[row]++;
endtask

task automatic expect_word(int row, arya_isa_pkg::mem_addr_t addr,
        arya_isa_pkg::word_t data);
    expects[row][expect_count[row]] = '{addr, data};
    expect_count[row]++;
endtask

// word that no instruction may touch
task automatic expect_untouched(int row, arya_isa_pkg::mem_addr_t addr);
    expect_word(row, addr, fill_word(addr));
endtask

task automatic build_table();
    arya_isa_pkg::imm_t  neg_imm;
    arya_isa_pkg::word_t op_a;
    arya_isa_pkg::word_t op_b;
    arya_isa_pkg::word_t ld_a;
    arya_isa_pkg::word_t ld_b;
    arya_isa_pkg::word_t ld_c;

    for (int r = 0; r < NUM_ROWS; r++) begin
        preset_count[r] = 0;
        expect_count[r] = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            programs[r][i] = arya_isa_pkg::NOP_INST;
        end
    end

    // row 0, alu ops, three nops between producer and consumer
    neg_imm = 16'hff0f;
    op_a    = 64'h1234;
    op_b    = {{48{neg_imm[15]}}, neg_imm};
    programs[0][0]  = itype(arya_isa_pkg::OP_ADDI, 1, 0, 16'h1234);
    programs[0][1]  = itype(arya_isa_pkg::OP_ADDI, 2, 0, neg_imm);
    programs[0][5]  = rtype(arya_isa_pkg::OP_ADD, 3, 1, 2);
    programs[0][6]  = rtype(arya_isa_pkg::OP_SUB, 4, 1, 2);
    programs[0][7]  = rtype(arya_isa_pkg::OP_AND, 5, 1, 2);
    programs[0][8]  = rtype(arya_isa_pkg::OP_OR, 6, 1, 2);
    programs[0][9]  = rtype(arya_isa_pkg::OP_XOR, 7, 1, 2);
    programs[0][10] = itype(arya_isa_pkg::OP_ADDI, 8, 1, 16'h8000);
    programs[0][14] = itype(arya_isa_pkg::OP_ST, 3, 0, 16'h0000);
    programs[0][15] = itype(arya_isa_pkg::OP_ST, 4, 0, 16'h0001);
    programs[0][16] = itype(arya_isa_pkg::OP_ST, 5, 0, 16'h0002);
    programs[0][17] = itype(arya_isa_pkg::OP_ST, 6, 0, 16'h0003);
    programs[0][18] = itype(arya_isa_pkg::OP_ST, 7, 0, 16'h0004);
    programs[0][19] = itype(arya_isa_pkg::OP_ST, 8, 0, 16'h0005);
    programs[0][20] = itype(arya_isa_pkg::OP_HALT, 0, 0, 16'h0000);
    expect_word(0, 10'h200, op_a + op_b);
    expect_word(0, 10'h201, op_a - op_b);
    expect_word(0, 10'h202, op_a & op_b);
    expect_word(0, 10'h203, op_a | op_b);
    expect_word(0, 10'h204, op_a ^ op_b);
    // 16'h8000 sign-extends negative
    expect_word(0, 10'h205, op_a + 64'hffff_ffff_ffff_8000);

    // row 1, loads, sum, stores, r0 as source and as dropped target
    ld_a = 64'h0123_4567_89ab_cdef;
    ld_b = 64'h1111_2222_3333_4444;
    ld_c = 64'hfedc_ba98_7654_3210;
    preset_word(1, 10'h210, ld_a);
    preset_word(1, 10'h211, ld_b);
    preset_word(1, 10'h212, ld_c);
    programs[1][0]  = itype(arya_isa_pkg::OP_LD, 1, 0, 16'h0010);
    programs[1][1]  = itype(arya_isa_pkg::OP_LD, 2, 0, 16'h0011);
    programs[1][2]  = itype(arya_isa_pkg::OP_LD, 3, 0, 16'h0012);
    programs[1][3]  = itype(arya_isa_pkg::OP_ADDI, 0, 0, 16'h7777);
    programs[1][5]  = rtype(arya_isa_pkg::OP_ADD, 4, 1, 2);
    programs[1][9]  = rtype(arya_isa_pkg::OP_ADD, 5, 4, 3);
    programs[1][10] = itype(arya_isa_pkg::OP_ADDI, 7, 0, 16'h0005);
    programs[1][14] = itype(arya_isa_pkg::OP_ST, 5, 0, 16'h0020);
    programs[1][15] = itype(arya_isa_pkg::OP_ST, 7, 0, 16'h0021);
    programs[1][16] = itype(arya_isa_pkg::OP_ST, 0, 0, 16'h0022);
    // base register r7 = 5, so 5 + 0x1e lands on 0x223
    programs[1][17] = itype(arya_isa_pkg::OP_ST, 4, 7, 16'h001e);
    programs[1][18] = itype(arya_isa_pkg::OP_HALT, 0, 0, 16'h0000);
    expect_word(1, 10'h210, ld_a);
    expect_word(1, 10'h220, ld_a + ld_b + ld_c);
    expect_word(1, 10'h221, 64'd5);
    expect_word(1, 10'h222, 64'd0);
    expect_word(1, 10'h223, ld_a + ld_b);

    // row 2, beq/bne taken and not taken, shadow and skipped stores
    programs[2][0]  = itype(arya_isa_pkg::OP_ADDI, 1, 0, 16'h0007);
    programs[2][1]  = itype(arya_isa_pkg::OP_ADDI, 2, 0, 16'h0007);
    programs[2][2]  = itype(arya_isa_pkg::OP_ADDI, 3, 0, 16'h0009);
    programs[2][6]  = branch_inst(arya_isa_pkg::OP_BEQ, 1, 2, 9'd8);
    programs[2][7]  = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0030);
    programs[2][8]  = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0031);
    programs[2][9]  = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0032);
    programs[2][10] = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0033);
    programs[2][14] = branch_inst(arya_isa_pkg::OP_BNE, 1, 3, 9'd8);
    programs[2][15] = itype(arya_isa_pkg::OP_ST, 3, 0, 16'h0034);
    programs[2][18] = itype(arya_isa_pkg::OP_ST, 3, 0, 16'h0035);
    programs[2][22] = branch_inst(arya_isa_pkg::OP_BEQ, 1, 3, 9'd6);
    programs[2][23] = itype(arya_isa_pkg::OP_ST, 2, 0, 16'h0036);
    programs[2][26] = itype(arya_isa_pkg::OP_ST, 2, 0, 16'h0037);
    // backward offset, not taken since r1 equals r2
    programs[2][27] = branch_inst(arya_isa_pkg::OP_BNE, 1, 2, arya_isa_pkg::pc_t'(-27));
    programs[2][31] = itype(arya_isa_pkg::OP_ST, 3, 0, 16'h0038);
    programs[2][32] = itype(arya_isa_pkg::OP_HALT, 0, 0, 16'h0000);
    expect_word(2, 10'h230, 64'd7);
    expect_word(2, 10'h231, 64'd7);
    expect_word(2, 10'h232, 64'd7);
    expect_untouched(2, 10'h233);
    expect_word(2, 10'h234, 64'd9);
    expect_untouched(2, 10'h235);
    expect_word(2, 10'h236, 64'd7);
    expect_word(2, 10'h237, 64'd7);
    expect_word(2, 10'h238, 64'd9);

    // row 3, store right before halt lands, store past the shadow never does
    programs[3][0] = itype(arya_isa_pkg::OP_ADDI, 1, 0, 16'h0abc);
    programs[3][4] = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0040);
    programs[3][5] = itype(arya_isa_pkg::OP_HALT, 0, 0, 16'h0000);
    programs[3][9] = itype(arya_isa_pkg::OP_ST, 1, 0, 16'h0041);
    expect_word(3, 10'h240, 64'h0abc);
    expect_untouched(3, 10'h241);
endtask

`endif

/* dv/arya_tb.sv */
`timescale 1ns/1ps

module arya_tb;

    localparam int CLK_PERIOD   = 4;
    // cycle budget per program row
    localparam int RUN_CYCLES   = 200;
    localparam int LOAD_CYCLES  = 180;
    localparam int DEBUG_CYCLES = 100;
    localparam int DEBUG_WORDS  = 16;

    logic                    clk;
    logic                    rst;
    logic                    run;
    logic                    setup_mem;
    logic                    verify_mem;
    arya_isa_pkg::mem_addr_t mem_addr;
    arya_isa_pkg::word_t     mem_data_in;
    arya_isa_pkg::word_t     mem_data_out;
    logic                    halted;
    integer                  seed;

    `include "arya_programs.svh"

    localparam int WATCHDOG_CYCLES = NUM_ROWS * (RUN_CYCLES + LOAD_CYCLES) + DEBUG_CYCLES;

    arya dut0 (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .setup_mem    (setup_mem),
        .verify_mem   (verify_mem),
        .mem_addr     (mem_addr),
        .mem_data_in  (mem_data_in),
        .mem_data_out (mem_data_out),
        .halted       (halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // only a core stuck before halt can run this long
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("watchdog expired, the core never halted");
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(string line);
        $display("%s", line);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(string name, arya_isa_pkg::word_t expected,
            arya_isa_pkg::word_t actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s expected %h, got %h",
                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        if (actual !== expected) begin
            report_failure($sformatf("** Error at %0d ns: %s expected %b, got %b",
                $time, name, expected, actual));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers
    //////////////////////////////////////////////////////////////////////

    // rst held for three edges, then halted must be low
    task automatic apply_reset();
        @(posedge clk);
        rst        <= 1'b1;
        run        <= 1'b0;
        setup_mem  <= 1'b0;
        verify_mem <= 1'b0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_flag("halted", 1'b0, halted);
    endtask

    // written at the following edge
    task automatic mem_write(arya_isa_pkg::mem_addr_t addr, arya_isa_pkg::word_t data);
        @(posedge clk);
        setup_mem   <= 1'b1;
        verify_mem  <= 1'b0;
        mem_addr    <= addr;
        mem_data_in <= data;
    endtask

    task automatic release_port();
        @(posedge clk);
        setup_mem  <= 1'b0;
        verify_mem <= 1'b0;
    endtask

    // one-cycle read, sampled mid-cycle
    task automatic mem_read(arya_isa_pkg::mem_addr_t addr, output arya_isa_pkg::word_t data);
        @(posedge clk);
        setup_mem  <= 1'b0;
        verify_mem <= 1'b1;
        mem_addr   <= addr;
        @(posedge clk);
        verify_mem <= 1'b0;
        @(negedge clk);
        data = mem_data_out;
    endtask

    //////////////////////////////////////////////////////////////////////
    // tests
    //////////////////////////////////////////////////////////////////////

    // one random word per 32-word slice, so no address repeats
    task automatic debug_port_test();
        arya_isa_pkg::mem_addr_t addrs [DEBUG_WORDS];
        arya_isa_pkg::word_t     data [DEBUG_WORDS];
        arya_isa_pkg::word_t     got;

        for (int i = 0; i < DEBUG_WORDS; i++) begin
            addrs[i] = DATA_BASE + arya_isa_pkg::mem_addr_t'(i * 32 + ($random(seed) & 31));
            data[i]  = {$random(seed), $random(seed)};
            mem_write(addrs[i], data[i]);
        end
        release_port();
        for (int i = 0; i < DEBUG_WORDS; i++) begin
            mem_read(addrs[i], got);
            check_word($sformatf("mem_data_out[%03h]", addrs[i]), data[i], got);
        end
    endtask

    task automatic run_row(int row);
        arya_isa_pkg::mem_addr_t addr;
        arya_isa_pkg::word_t     got;

        apply_reset();
        // clear the data window, then presets, then the program
        for (int i = 0; i < FILL_WORDS; i++) begin
            addr = DATA_BASE + arya_isa_pkg::mem_addr_t'(i);
            mem_write(addr, fill_word(addr));
        end
        for (int p = 0; p < preset_count[row]; p++) begin
            mem_write(presets[row][p].addr, presets[row][p].data);
        end
        for (int i = 0; i < PROG_LEN; i++) begin
            mem_write(arya_isa_pkg::mem_addr_t'(i), arya_isa_pkg::word_t'(programs[row][i]));
        end
        release_port();

        @(posedge clk);
        run <= 1'b1;
        @(negedge clk);
        while (halted !== 1'b1) begin
            @(negedge clk);
        end
        // core stays frozen with run still high
        repeat (4) @(negedge clk);
        check_flag("halted", 1'b1, halted);
        @(posedge clk);
        run <= 1'b0;

        for (int e = 0; e < expect_count[row]; e++) begin
            mem_read(expects[row][e].addr, got);
            check_word($sformatf("row %0d mem_data_out[%03h]", row, expects[row][e].addr),
                expects[row][e].data, got);
        end
    endtask

    initial begin
        rst         = 1'b1;
        run         = 1'b0;
        setup_mem   = 1'b0;
        verify_mem  = 1'b0;
        mem_addr    = '0;
        mem_data_in = '0;
        seed        = 32'ha2c1_2bcf;
        build_table();

        apply_reset();
        debug_port_test();
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* files.f */
+incdir+dv
verilog/arya_isa_pkg.sv
verilog/arya_pipe_pkg.sv
verilog/fetch_unit.sv
verilog/inst_decoder.sv
verilog/regfile.sv
verilog/execute_stage.sv
verilog/dualport_mem.sv
verilog/arya.sv
dv/arya_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -rf obj_dir sim.log &&
verilator --binary --timing -Wno-fatal --top-module arya_tb -f files.f -o arya_sim &&
./obj_dir/arya_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "TESTS PASSED" sim.log 2>/dev/null && echo "run ok" || { echo "run failed"; exit 1; }

/* verilog/arya.sv */
`timescale 1ns/1ps

module arya (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    setup_mem,
    input  logic                    verify_mem,
    input  arya_isa_pkg::mem_addr_t mem_addr,
    input  arya_isa_pkg::word_t     mem_data_in,
    output arya_isa_pkg::word_t     mem_data_out,
    output logic                    halted
);

    logic                    advance;
    logic                    branch_taken;
    arya_isa_pkg::pc_t       branch_target;
    arya_isa_pkg::pc_t       pc;
    arya_isa_pkg::pc_t       fetch_pc;
    logic                    fetch_valid;
    arya_isa_pkg::mem_addr_t porta_addr;
    logic                    porta_we;
    logic                    porta_en;
    arya_isa_pkg::word_t     douta;
    arya_isa_pkg::word_t     doutb;
    arya_isa_pkg::mem_addr_t portb_addr;
    arya_isa_pkg::word_t     portb_wdata;
    logic                    portb_we;
    arya_isa_pkg::inst_t     dec_inst;
    arya_isa_pkg::reg_addr_t rs1_addr;
    arya_isa_pkg::reg_addr_t rs2_addr;
    arya_isa_pkg::word_t     rs1_data;
    arya_isa_pkg::word_t     rs2_data;
    arya_isa_pkg::word_t     wb_data;
    arya_pipe_pkg::dec_ex_t  dec;
    arya_pipe_pkg::dec_ex_t  de;
    arya_pipe_pkg::ex_mem_t  em;
    arya_pipe_pkg::mem_wb_t  mw;

    // whole core freezes on run low or after halt
    assign advance = run & ~halted;

    ////////////////////////////////////////////////////////////////////////
    // fetch and memory
    ////////////////////////////////////////////////////////////////////////

    fetch_unit fetch0 (
        .clk           (clk),
        .rst           (rst),
        .run           (run),
        .advance       (advance),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .setup_mem     (setup_mem),
        .dbg_addr      (mem_addr),
        .porta_addr    (porta_addr),
        .porta_we      (porta_we),
        .pc            (pc)
    );

    // debug port only clocks on a setup or verify
    assign porta_en = run ? advance : (setup_mem | verify_mem);

    dualport_mem mem0 (
        .clk   (clk),
        .ena   (porta_en),
        .enb   (advance),
        .addra (porta_addr),
        .addrb (portb_addr),
        .dina  (mem_data_in),
        .dinb  (portb_wdata),
        .wea   (porta_we),
        .web   (portb_we),
        .douta (douta),
        .doutb (doutb)
    );

    assign mem_data_out = douta;

    // douta holds a real instruction only after a core fetch
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= advance;
        end
    end

    // pc of the word now on douta
    always_ff @(posedge clk) begin
        if (advance) begin
            fetch_pc <= pc;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////

    assign dec_inst = (run && fetch_valid) ? douta[31:0] : arya_isa_pkg::NOP_INST;

    inst_decoder dec0 (
        .inst     (dec_inst),
        .pc       (fetch_pc),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .dec      (dec)
    );

    regfile rf0 (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (mw.wr_en & advance),
        .wr_addr  (mw.wr_addr),
        .wr_data  (wb_data)
    );

    // decode -> execute
    always_ff @(posedge clk) begin
        if (rst) begin
            de.ctrl <= '0;
        end else if (advance) begin
            de <= dec;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // execute, memory, writeback
    ////////////////////////////////////////////////////////////////////////

    execute_stage ex0 (
        .clk           (clk),
        .rst           (rst),
        .advance       (advance),
        .de            (de),
        .em            (em),
        .portb_addr    (portb_addr),
        .portb_wdata   (portb_wdata),
        .portb_we      (portb_we),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    // load data arrives from port B in the memory cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mw.wr_en      <= 1'b0;
            mw.mem_to_reg <= 1'b0;
            mw.halt       <= 1'b0;
        end else if (advance) begin
            mw.wr_en      <= em.ctrl.wr_en;
            mw.mem_to_reg <= em.ctrl.mem_to_reg;
            mw.halt       <= em.ctrl.halt;
            mw.accum      <= em.accum;
            mw.load_data  <= doutb;
            mw.wr_addr    <= em.wr_addr;
        end
    end

    assign wb_data = mw.mem_to_reg ? mw.load_data : mw.accum;

    // halt in writeback, older instructions already retired
    always_ff @(posedge clk) begin
        if (rst) begin
            halted <= 1'b0;
        end else if (advance && mw.halt) begin
            halted <= 1'b1;
        end
    end

endmodule

/* verilog/arya_isa_pkg.sv */
package arya_isa_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int WORD_W     = 64;
    localparam int INST_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int PC_W       = 9;
    localparam int MEM_ADDR_W = 10;
    localparam int IMM_W      = 16;

    // data half of memory lives above this bit
    localparam int DATA_BASE_BIT = 9;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [INST_W-1:0]     inst_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [PC_W-1:0]       pc_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [IMM_W-1:0]      imm_t;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // opcode sits in inst[31:28], codes 11..14 are unused
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,
        OP_ADD  = 4'h1,
        OP_SUB  = 4'h2,
        OP_AND  = 4'h3,
        OP_OR   = 4'h4,
        OP_XOR  = 4'h5,
        OP_ADDI = 4'h6,
        OP_LD   = 4'h7,
        OP_ST   = 4'h8,
        OP_BEQ  = 4'h9,
        OP_BNE  = 4'ha,
        OP_HALT = 4'hf
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // all-zero word decodes as nop
    localparam inst_t NOP_INST = '0;

endpackage

/* verilog/arya_pipe_pkg.sv */
package arya_pipe_pkg;

    // decoded control word, carried down the pipe
    typedef struct packed {
        logic                  wr_en;
        logic                  mem_write;
        logic                  mem_to_reg;
        logic                  beq;
        logic                  bne;
        logic                  halt;
        arya_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    //////////////////////////////////////////////////////////////////////
    // stage records
    //////////////////////////////////////////////////////////////////////

    // decode -> execute
    typedef struct packed {
        ctrl_t                   ctrl;
        arya_isa_pkg::pc_t       pc;
        arya_isa_pkg::word_t     operand_a;
        arya_isa_pkg::word_t     operand_b;
        arya_isa_pkg::word_t     store_data;
        arya_isa_pkg::reg_addr_t wr_addr;
        arya_isa_pkg::pc_t       branch_offset;
    } dec_ex_t;

    // execute -> memory
    typedef struct packed {
        ctrl_t                   ctrl;
        arya_isa_pkg::word_t     accum;
        logic                    zero;
        arya_isa_pkg::pc_t       branch_target;
        arya_isa_pkg::reg_addr_t wr_addr;
    } ex_mem_t;

    // memory -> writeback
    typedef struct packed {
        logic                    wr_en;
        logic                    mem_to_reg;
        logic                    halt;
        arya_isa_pkg::word_t     accum;
        arya_isa_pkg::word_t     load_data;
        arya_isa_pkg::reg_addr_t wr_addr;
    } mem_wb_t;

endpackage

/* verilog/dualport_mem.sv */
`timescale 1ns/1ps

module dualport_mem (
    input  logic                    clk,
    input  logic                    ena,
    input  logic                    enb,
    input  arya_isa_pkg::mem_addr_t addra,
    input  arya_isa_pkg::mem_addr_t addrb,
    input  arya_isa_pkg::word_t     dina,
    input  arya_isa_pkg::word_t     dinb,
    input  logic                    wea,
    input  logic                    web,
    output arya_isa_pkg::word_t     douta,
    output arya_isa_pkg::word_t     doutb
);

    // low half instructions, high half data
    arya_isa_pkg::word_t mem [1024];

    // read-first on both ports
    // port B wins a same-address write collision
    always_ff @(posedge clk) begin
        if (ena) begin
            douta <= mem[addra];
            if (wea) begin
                mem[addra] <= dina;
            end
        end
        if (enb) begin
            doutb <= mem[addrb];
            if (web) begin
                mem[addrb] <= dinb;
            end
        end
    end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    advance,
    input  arya_pipe_pkg::dec_ex_t  de,
    output arya_pipe_pkg::ex_mem_t  em,
    output arya_isa_pkg::mem_addr_t portb_addr,
    output arya_isa_pkg::word_t     portb_wdata,
    output logic                    portb_we,
    output logic                    branch_taken,
    output arya_isa_pkg::pc_t       branch_target
);

    arya_isa_pkg::word_t accum;
    logic                zero;
    arya_isa_pkg::pc_t   target;

    ////////////////////////////////////////////////////////////////////////
    // ALU and branch adder
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (de.ctrl.alu_op)
            arya_isa_pkg::ALU_SUB: accum = de.operand_a - de.operand_b;
            arya_isa_pkg::ALU_AND: accum = de.operand_a & de.operand_b;
            arya_isa_pkg::ALU_OR:  accum = de.operand_a | de.operand_b;
            arya_isa_pkg::ALU_XOR: accum = de.operand_a ^ de.operand_b;
            default:               accum = de.operand_a + de.operand_b;
        endcase
    end

    assign zero = (accum == '0);

    // offset is two's complement, wraps within instruction space
    assign target = de.pc + de.branch_offset;

    ////////////////////////////////////////////////////////////////////////
    // port B, driven in the execute cycle
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        portb_addr = arya_isa_pkg::mem_addr_t'(accum[arya_isa_pkg::DATA_BASE_BIT-1:0]);
        portb_addr[arya_isa_pkg::DATA_BASE_BIT] = 1'b1;
    end

    assign portb_wdata = de.store_data;
    assign portb_we    = de.ctrl.mem_write & advance;

    ////////////////////////////////////////////////////////////////////////
    // execute -> memory register
    ////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            em.ctrl <= '0;
        end else if (advance) begin
            em.ctrl          <= de.ctrl;
            em.accum         <= accum;
            em.zero          <= zero;
            em.branch_target <= target;
            em.wr_addr       <= de.wr_addr;
        end
    end

    // branch resolves in the memory stage
    assign branch_taken  = (em.ctrl.beq & em.zero) | (em.ctrl.bne & ~em.zero);
    assign branch_target = em.branch_target;

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    run,
    input  logic                    advance,
    input  logic                    branch_taken,
    input  arya_isa_pkg::pc_t       branch_target,
    input  logic                    setup_mem,
    input  arya_isa_pkg::mem_addr_t dbg_addr,
    output arya_isa_pkg::mem_addr_t porta_addr,
    output logic                    porta_we,
    output arya_isa_pkg::pc_t       pc
);

    arya_isa_pkg::pc_t pc_next;

    // redirect wins over sequential fetch
    always_comb begin
        if (branch_taken) begin
            pc_next = branch_target;
        end else begin
            pc_next = pc + 1'b1;
        end
    end

    // pc only moves with the rest of the core
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////
    // port A mux
    ////////////////////////////////////////////////////////////////////////

    // debug address only while stopped
    // instruction words sit in the low half, so pc is zero-extended
    assign porta_addr = run ? arya_isa_pkg::mem_addr_t'(pc) : dbg_addr;

    // loader writes are blocked while running
    assign porta_we = setup_mem & ~run;

endmodule

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  arya_isa_pkg::inst_t     inst,
    input  arya_isa_pkg::pc_t       pc,
    output arya_isa_pkg::reg_addr_t rs1_addr,
    output arya_isa_pkg::reg_addr_t rs2_addr,
    input  arya_isa_pkg::word_t     rs1_data,
    input  arya_isa_pkg::word_t     rs2_data,
    output arya_pipe_pkg::dec_ex_t  dec
);

    arya_isa_pkg::opcode_e   opcode;
    arya_isa_pkg::reg_addr_t rd;
    arya_isa_pkg::imm_t      imm;
    arya_isa_pkg::word_t     imm_ext;
    arya_pipe_pkg::ctrl_t    ctrl;
    logic                    use_imm;

    ////////////////////////////////////////////////////////////////////////
    // field split
    ////////////////////////////////////////////////////////////////////////

    assign opcode  = arya_isa_pkg::opcode_e'(inst[31:28]);
    assign rd      = inst[27:23];
    assign imm     = inst[15:0];
    assign imm_ext = arya_isa_pkg::word_t'($signed(imm));

    assign rs1_addr = inst[22:18];
    // st reads its source through the rd field
    assign rs2_addr = (opcode == arya_isa_pkg::OP_ST) ? rd : inst[17:13];

    ////////////////////////////////////////////////////////////////////////
    // opcode to control
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = arya_isa_pkg::ALU_ADD;
        use_imm     = 1'b0;
        case (opcode)
            arya_isa_pkg::OP_ADD: begin
                ctrl.wr_en = 1'b1;
            end
            arya_isa_pkg::OP_SUB: begin
                ctrl.wr_en  = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_SUB;
            end
            arya_isa_pkg::OP_AND: begin
                ctrl.wr_en  = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_AND;
            end
            arya_isa_pkg::OP_OR: begin
                ctrl.wr_en  = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_OR;
            end
            arya_isa_pkg::OP_XOR: begin
                ctrl.wr_en  = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_XOR;
            end
            arya_isa_pkg::OP_ADDI: begin
                ctrl.wr_en = 1'b1;
                use_imm    = 1'b1;
            end
            // address = rs1 + imm for both memory ops
            arya_isa_pkg::OP_LD: begin
                ctrl.wr_en      = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                use_imm         = 1'b1;
            end
            arya_isa_pkg::OP_ST: begin
                ctrl.mem_write = 1'b1;
                use_imm        = 1'b1;
            end
            // compare by subtraction, zero flag decides
            arya_isa_pkg::OP_BEQ: begin
                ctrl.beq    = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_SUB;
            end
            arya_isa_pkg::OP_BNE: begin
                ctrl.bne    = 1'b1;
                ctrl.alu_op = arya_isa_pkg::ALU_SUB;
            end
            arya_isa_pkg::OP_HALT: begin
                ctrl.halt = 1'b1;
            end
            // nop and unused codes
            default: begin
                ctrl = '0;
            end
        endcase
    end

    always_comb begin
        dec.ctrl          = ctrl;
        dec.pc            = pc;
        dec.operand_a     = rs1_data;
        dec.operand_b     = use_imm ? imm_ext : rs2_data;
        dec.store_data    = rs2_data;
        dec.wr_addr       = rd;
        dec.branch_offset = inst[8:0];
    end

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile (
    input  logic                    clk,
    input  logic                    rst,
    input  arya_isa_pkg::reg_addr_t rs1_addr,
    input  arya_isa_pkg::reg_addr_t rs2_addr,
    output arya_isa_pkg::word_t     rs1_data,
    output arya_isa_pkg::word_t     rs2_data,
    input  logic                    wr_en,
    input  arya_isa_pkg::reg_addr_t wr_addr,
    input  arya_isa_pkg::word_t     wr_data
);

    arya_isa_pkg::word_t regs [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // async reads, r0 hardwired to zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule
